// File: build.f
source/lsu_pkg.sv
source/wb_pkg.sv
source/store_aligner.sv
source/load_aligner.sv
source/wishbone_controller.sv
source/wb_data_ram.sv
source/data_mem_subsys.sv
verif/data_mem_subsys_assert.sv
verif/data_mem_subsys_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the data memory testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -j 0 \
    --top-module data_mem_subsys_tb \
    -f build.f \
    -o data_mem_subsys_tb \
    && ./obj_dir/data_mem_subsys_tb 2>&1 | tee "$LOG" \
    || { echo "Build or simulation aborted"; exit 1; }

# Result is taken from the log
grep -q "Test FAILED" "$LOG" \
    && { echo "Simulation failed"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }

// File: source/data_mem_subsys.sv
`default_nettype none

module data_mem_subsys (
    input  logic                            clk_i,
    input  logic                            rst_n_i,

    // Processor load/store port
    input  logic [wb_pkg::ADDR_W-1:0]       proc_addr_i,
    input  logic [wb_pkg::DATA_W-1:0]       proc_wdata_i,
    input  logic                            proc_read_i,
    input  logic                            proc_write_i,
    input  lsu_pkg::mem_op_e                proc_op_i,
    output logic [wb_pkg::DATA_W-1:0]       proc_rdata_o,
    output logic                            proc_ack_o,
    output logic                            proc_err_o,
    output logic                            proc_stall_o,

    // Debug access port
    input  logic                            core_halted_i,
    input  logic                            dbg_en_i,
    input  logic                            dbg_wr_i,
    input  logic [lsu_pkg::DBG_ST_W-1:0]    dbg_st_i,
    input  logic [wb_pkg::ADDR_W-1:0]       dbg_addr_i,
    input  logic [wb_pkg::DATA_W-1:0]       dbg_wdata_i,
    output logic [wb_pkg::DATA_W-1:0]       dbg_rdata_o,
    output logic                            dbg_done_o
);

    // ====================
    // Wishbone nets
    // ====================

    logic [wb_pkg::ADDR_W-1:0] wb_adr;
    logic [wb_pkg::DATA_W-1:0] wb_dat_m2s;  // Master to slave
    logic [wb_pkg::DATA_W-1:0] wb_dat_s2m;  // Slave to master
    logic [wb_pkg::SEL_W-1:0]  wb_sel;
    logic                      wb_we;
    logic                      wb_cyc;
    logic                      wb_stb;
    logic                      wb_ack;
    logic                      wb_err;

    wishbone_controller u_ctrl (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .proc_addr_i   (proc_addr_i),
        .proc_wdata_i  (proc_wdata_i),
        .proc_read_i   (proc_read_i),
        .proc_write_i  (proc_write_i),
        .proc_op_i     (proc_op_i),
        .proc_rdata_o  (proc_rdata_o),
        .proc_ack_o    (proc_ack_o),
        .proc_err_o    (proc_err_o),
        .proc_stall_o  (proc_stall_o),
        .core_halted_i (core_halted_i),
        .dbg_en_i      (dbg_en_i),
        .dbg_wr_i      (dbg_wr_i),
        .dbg_st_i      (dbg_st_i),
        .dbg_addr_i    (dbg_addr_i),
        .dbg_wdata_i   (dbg_wdata_i),
        .dbg_rdata_o   (dbg_rdata_o),
        .dbg_done_o    (dbg_done_o),
        .wb_adr_o      (wb_adr),
        .wb_dat_o      (wb_dat_m2s),
        .wb_sel_o      (wb_sel),
        .wb_we_o       (wb_we),
        .wb_cyc_o      (wb_cyc),
        .wb_stb_o      (wb_stb),
        .wb_dat_i      (wb_dat_s2m),
        .wb_ack_i      (wb_ack),
        .wb_err_i      (wb_err)
    );

    wb_data_ram u_ram (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_m2s),
        .wb_sel_i (wb_sel),
        .wb_we_i  (wb_we),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_dat_o (wb_dat_s2m),
        .wb_ack_o (wb_ack),
        .wb_err_o (wb_err)
    );

endmodule

`default_nettype wire

// File: source/load_aligner.sv
`default_nettype none

module load_aligner (
    input  logic [wb_pkg::DATA_W-1:0] rdata_i,    // Raw bus word
    input  lsu_pkg::mem_op_e          op_i,
    input  logic [1:0]                addr_lo_i,  // Byte offset of the load
    output logic [wb_pkg::DATA_W-1:0] data_o
);

    localparam int B_PAD = wb_pkg::DATA_W - 8;   // Extension bits above a byte
    localparam int H_PAD = wb_pkg::DATA_W - 16;  // Extension bits above a half

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    // ====================
    // Lane extraction
    // ====================

    // Addressed byte, offset times 8
    assign byte_sel = rdata_i[{addr_lo_i, 3'b000} +: 8];

    // Upper or lower half by addr bit 1
    assign half_sel = rdata_i[{addr_lo_i[1], 4'b0000} +: 16];

    // ====================
    // Extension
    // ====================

    always_comb begin
        case (op_i)
            lsu_pkg::OP_LB: begin
                data_o = {{B_PAD{byte_sel[7]}}, byte_sel};    // Sign from bit 7
            end
            lsu_pkg::OP_LH: begin
                data_o = {{H_PAD{half_sel[15]}}, half_sel};   // Sign from bit 15
            end
            lsu_pkg::OP_LBU: begin
                data_o = {{B_PAD{1'b0}}, byte_sel};
            end
            lsu_pkg::OP_LHU: begin
                data_o = {{H_PAD{1'b0}}, half_sel};
            end
            default: begin
                // LW and unused funct3 codes
                data_o = rdata_i;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // ====================
    // Memory operations
    // ====================

    // RISC-V funct3 encodings of the load ops
    // Stores reuse LB, LH and LW as byte, half and word
    typedef enum logic [2:0] {
        OP_LB  = 3'b000,    // Signed byte
        OP_LH  = 3'b001,    // Signed half
        OP_LW  = 3'b010,    // Full word
        OP_LBU = 3'b100,    // Unsigned byte
        OP_LHU = 3'b101     // Unsigned half
    } mem_op_e;

    // Store width
    // Same values as the low two funct3 bits
    typedef enum logic [1:0] {
        SZ_BYTE = 2'b00,
        SZ_HALF = 2'b01,
        SZ_WORD = 2'b10
    } store_size_e;

    // ====================
    // Debug access
    // ====================

    // Debug size field width
    // Low 3 bits carry a mem_op_e on reads
    // Low 2 bits carry a store_size_e on writes
    localparam int DBG_ST_W = 4;

endpackage

`default_nettype wire

// File: source/store_aligner.sv
`default_nettype none

module store_aligner (
    input  logic [wb_pkg::DATA_W-1:0] wdata_i,    // Unaligned store data, LSB first
    input  lsu_pkg::store_size_e      size_i,
    input  logic [1:0]                addr_lo_i,  // Byte offset in word
    input  logic                      write_i,
    output logic [wb_pkg::SEL_W-1:0]  wsel_o,
    output logic [wb_pkg::DATA_W-1:0] data_o
);

    // ====================
    // Lane placement
    // ====================

    always_comb begin
        // Word store by default
        data_o = wdata_i;
        wsel_o = '1;

        case (size_i)
            lsu_pkg::SZ_BYTE: begin
                // Byte copied to every lane, one select
                data_o = {wb_pkg::SEL_W{wdata_i[7:0]}};
                wsel_o = wb_pkg::SEL_W'(1) << addr_lo_i;
            end
            lsu_pkg::SZ_HALF: begin
                // Half in lanes 1:0 or 3:2 by addr bit 1
                data_o = {(wb_pkg::SEL_W / 2){wdata_i[15:0]}};
                wsel_o = wb_pkg::SEL_W'(2'b11) << {addr_lo_i[1], 1'b0};
            end
            default: begin
                data_o = wdata_i;   // Full word, all lanes
                wsel_o = '1;
            end
        endcase

        // Reads always fetch whole word
        if (!write_i) begin
            wsel_o = '1;
        end
    end

endmodule

`default_nettype wire

// File: source/wb_data_ram.sv
`default_nettype none

module wb_data_ram (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic [wb_pkg::ADDR_W-1:0] wb_adr_i,
    input  logic [wb_pkg::DATA_W-1:0] wb_dat_i,
    input  logic [wb_pkg::SEL_W-1:0]  wb_sel_i,
    input  logic                      wb_we_i,
    input  logic                      wb_cyc_i,
    input  logic                      wb_stb_i,
    output logic [wb_pkg::DATA_W-1:0] wb_dat_o,
    output logic                      wb_ack_o,
    output logic                      wb_err_o
);

    typedef enum logic [1:0] {
        IDLE,   // Waiting for strobe
        WAIT,   // Counting wait states
        RESP    // Ack/err cycle
    } ram_state_e;

    ram_state_e                 state_q;
    logic [wb_pkg::CNT_W-1:0]   cnt_q;
    logic [wb_pkg::DATA_W-1:0]  mem [wb_pkg::RAM_WORDS];
    logic [wb_pkg::RAM_AW-1:0]  word_idx;
    logic                       in_range;
    logic                       last_wait;  // Access fires this cycle

    assign word_idx  = wb_adr_i[wb_pkg::RAM_AW+1:2];
    assign in_range  = wb_adr_i < wb_pkg::RAM_BYTES;
    assign last_wait = (state_q == WAIT) && (cnt_q == wb_pkg::WAIT_LAST);

    // ====================
    // Control FSM
    // ====================

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q  <= IDLE;
            cnt_q    <= '0;
            wb_ack_o <= 1'b0;
            wb_err_o <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (wb_cyc_i && wb_stb_i) begin
                        state_q <= WAIT;
                        cnt_q   <= '0;
                    end
                end
                WAIT: begin
                    if (last_wait) begin
                        wb_ack_o <= in_range;
                        wb_err_o <= ~in_range;  // Past end of RAM
                        state_q  <= RESP;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: begin
                    // One-cycle pulse, then back to idle
                    wb_ack_o <= 1'b0;
                    wb_err_o <= 1'b0;
                    state_q  <= IDLE;
                end
            endcase
        end
    end

    // ====================
    // Storage
    // ====================

    // Contents cleared on reset, byte-enabled writes
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int w = 0; w < wb_pkg::RAM_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (last_wait && in_range && wb_we_i) begin
            for (int b = 0; b < wb_pkg::SEL_W; b++) begin
                if (wb_sel_i[b]) begin
                    mem[word_idx][8*b +: 8] <= wb_dat_i[8*b +: 8];
                end
            end
        end
    end

    // Read data lands with ack
    always_ff @(posedge clk_i) begin
        if (last_wait && in_range && !wb_we_i) begin
            wb_dat_o <= mem[word_idx];
        end
    end

endmodule

`default_nettype wire

// File: source/wb_pkg.sv
`default_nettype none

package wb_pkg;

    // ====================
    // Bus widths
    // ====================

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int SEL_W  = DATA_W / 8;  // One select per byte lane

    // ====================
    // Data RAM
    // ====================

    localparam int RAM_WORDS = 256;
    localparam int RAM_AW    = $clog2(RAM_WORDS);        // Word index width
    localparam logic [ADDR_W-1:0] RAM_BYTES = ADDR_W'(RAM_WORDS * 4);  // First bad addr

    // Cycles from strobe accept to ack/err, at least 1
    localparam int WAIT_STATES = 2;
    localparam int CNT_W = (WAIT_STATES > 1) ? $clog2(WAIT_STATES) : 1;
    localparam logic [CNT_W-1:0] WAIT_LAST = CNT_W'(WAIT_STATES - 1);  // Last wait count

endpackage

`default_nettype wire

// File: source/wishbone_controller.sv
`default_nettype none

module wishbone_controller (
    input  logic                            clk_i,
    input  logic                            rst_n_i,

    // Processor side
    input  logic [wb_pkg::ADDR_W-1:0]       proc_addr_i,
    input  logic [wb_pkg::DATA_W-1:0]       proc_wdata_i,
    input  logic                            proc_read_i,
    input  logic                            proc_write_i,
    input  lsu_pkg::mem_op_e                proc_op_i,
    output logic [wb_pkg::DATA_W-1:0]       proc_rdata_o,   // Aligned load result
    output logic                            proc_ack_o,
    output logic                            proc_err_o,
    output logic                            proc_stall_o,

    // Debug side, only while halted
    input  logic                            core_halted_i,
    input  logic                            dbg_en_i,
    input  logic                            dbg_wr_i,
    input  logic [lsu_pkg::DBG_ST_W-1:0]    dbg_st_i,
    input  logic [wb_pkg::ADDR_W-1:0]       dbg_addr_i,
    input  logic [wb_pkg::DATA_W-1:0]       dbg_wdata_i,
    output logic [wb_pkg::DATA_W-1:0]       dbg_rdata_o,    // Raw bus word
    output logic                            dbg_done_o,

    // Wishbone master
    output logic [wb_pkg::ADDR_W-1:0]       wb_adr_o,
    output logic [wb_pkg::DATA_W-1:0]       wb_dat_o,
    output logic [wb_pkg::SEL_W-1:0]        wb_sel_o,
    output logic                            wb_we_o,
    output logic                            wb_cyc_o,
    output logic                            wb_stb_o,
    input  logic [wb_pkg::DATA_W-1:0]       wb_dat_i,
    input  logic                            wb_ack_i,
    input  logic                            wb_err_i
);

    logic                      proc_req;       // Read or write pending
    logic                      bus_done;       // Ack or err from slave
    logic [wb_pkg::DATA_W-1:0] st_wdata;
    lsu_pkg::store_size_e      st_size;
    logic                      st_write;
    logic [1:0]                addr_lo_q;
    lsu_pkg::mem_op_e          op_q;

    // ====================
    // Processor cycle
    // ====================

    assign proc_req = proc_read_i | proc_write_i;
    assign bus_done = wb_ack_i | wb_err_i;

    // Halted core sees no response
    assign proc_ack_o   = bus_done & ~core_halted_i;
    assign proc_err_o   = wb_err_i & ~core_halted_i;
    assign proc_stall_o = proc_req & ~proc_ack_o;   // Wait states show up here

    // Low addr bits and op for load alignment
    // Request is held through the wait, so copy matches at ack
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            addr_lo_q <= 2'b00;
            op_q      <= lsu_pkg::OP_LW;
        end else begin
            addr_lo_q <= proc_addr_i[1:0];
            op_q      <= proc_op_i;
        end
    end

    load_aligner u_load_aligner (
        .rdata_i   (wb_dat_i),
        .op_i      (op_q),
        .addr_lo_i (addr_lo_q),
        .data_o    (proc_rdata_o)
    );

    // ====================
    // Debug cycle
    // ====================

    assign dbg_rdata_o = wb_dat_i;                  // No alignment on debug reads
    assign dbg_done_o  = bus_done & core_halted_i;

    // ====================
    // Store path
    // ====================

    // Fed by whoever owns the bus
    assign st_wdata = core_halted_i ? dbg_wdata_i : proc_wdata_i;
    assign st_write = core_halted_i ? dbg_wr_i : proc_write_i;

    // Store funct3 low bits line up with store_size_e
    assign st_size = core_halted_i ? lsu_pkg::store_size_e'(dbg_st_i[1:0])
                                   : lsu_pkg::store_size_e'(proc_op_i[1:0]);

    store_aligner u_store_aligner (
        .wdata_i   (st_wdata),
        .size_i    (st_size),
        .addr_lo_i (wb_adr_o[1:0]),
        .write_i   (st_write),
        .wsel_o    (wb_sel_o),
        .data_o    (wb_dat_o)
    );

    // ====================
    // Bus master mux
    // ====================

    always_comb begin
        if (core_halted_i) begin
            // Debug port owns the bus
            wb_adr_o = dbg_addr_i;
            wb_we_o  = dbg_wr_i;
            wb_cyc_o = dbg_en_i;
            wb_stb_o = dbg_en_i;
        end else begin
            wb_adr_o = proc_addr_i;
            wb_we_o  = proc_write_i;
            wb_cyc_o = proc_req;
            wb_stb_o = proc_req;    // Held until ack or err
        end
    end

endmodule

`default_nettype wire

// File: verif/data_mem_subsys_assert.sv
`default_nettype none

module data_mem_subsys_assert (
    input logic                      clk_i,
    input logic                      rst_n_i,
    input logic                      core_halted_i,
    input logic                      proc_ack_i,   // Controller ack to the core
    input logic [wb_pkg::ADDR_W-1:0] wb_adr_i,
    input logic [wb_pkg::DATA_W-1:0] wb_wdat_i,    // Master write data
    input logic [wb_pkg::SEL_W-1:0]  wb_sel_i,
    input logic                      wb_we_i,
    input logic                      wb_cyc_i,
    input logic                      wb_stb_i,
    input logic                      wb_ack_i,
    input logic                      wb_err_i
);

    // ====================
    // Wishbone protocol
    // ====================

    stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_stb_i |-> wb_cyc_i)
        else $error("wishbone stb high outside cyc");

    ack_err_apart: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(wb_ack_i && wb_err_i))
        else $error("wishbone ack and err high together");

    // Master holds the cycle until the slave answers
    held_until_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_stb_i && !wb_ack_i && !wb_err_i |=>
            wb_stb_i && $stable(wb_adr_i) && $stable(wb_wdat_i) &&
            $stable(wb_sel_i) && $stable(wb_we_i))
        else $error("wishbone master changed a pending cycle");

    // ====================
    // Processor handshake
    // ====================

    // Ack to the core only for a cycle accepted outside the halt
    no_ack_halted: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        proc_ack_i |-> !$past(core_halted_i, wb_pkg::WAIT_STATES + 1))
        else $error("processor ack for a cycle started while halted");

endmodule

bind wishbone_controller data_mem_subsys_assert u_assert (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .core_halted_i (core_halted_i),
    .proc_ack_i    (proc_ack_o),
    .wb_adr_i      (wb_adr_o),
    .wb_wdat_i     (wb_dat_o),
    .wb_sel_i      (wb_sel_o),
    .wb_we_i       (wb_we_o),
    .wb_cyc_i      (wb_cyc_o),
    .wb_stb_i      (wb_stb_o),
    .wb_ack_i      (wb_ack_i),
    .wb_err_i      (wb_err_i)
);

`default_nettype wire

// File: verif/data_mem_subsys_tb.sv
`default_nettype none

module data_mem_subsys_tb;

    localparam int TIMEOUT = 50;                 // Cycles allowed per response
    localparam int SH_AW   = wb_pkg::RAM_AW + 2; // Byte index width of the shadow

    logic                         clk_i;
    logic                         rst_n_i;
    logic [wb_pkg::ADDR_W-1:0]    proc_addr_i;
    logic [wb_pkg::DATA_W-1:0]    proc_wdata_i;
    logic                         proc_read_i;
    logic                         proc_write_i;
    lsu_pkg::mem_op_e             proc_op_i;
    logic [wb_pkg::DATA_W-1:0]    proc_rdata_o;
    logic                         proc_ack_o;
    logic                         proc_err_o;
    logic                         proc_stall_o;
    logic                         core_halted_i;
    logic                         dbg_en_i;
    logic                         dbg_wr_i;
    logic [lsu_pkg::DBG_ST_W-1:0] dbg_st_i;
    logic [wb_pkg::ADDR_W-1:0]    dbg_addr_i;
    logic [wb_pkg::DATA_W-1:0]    dbg_wdata_i;
    logic [wb_pkg::DATA_W-1:0]    dbg_rdata_o;
    logic                         dbg_done_o;

    logic [15:0] lfsr_q;
    logic [7:0]  shadow [wb_pkg::RAM_WORDS*4];  // Byte image of the RAM
    int          errors;
    int          checks;

    // Expected response of the access in flight
    logic        proc_pending;
    logic        exp_read;
    logic        exp_err;
    logic [31:0] exp_rdata;
    logic        dbg_pending;
    logic        dbg_exp_read;
    logic [31:0] dbg_exp_word;

    data_mem_subsys dut (.*);

    always #10 clk_i = ~clk_i;

    // ====================
    // Helpers
    // ====================

    // Fibonacci LFSR, taps 16 14 13 11, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
            r      = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    function automatic logic [7:0] shadow_byte(input logic [31:0] a);
        return shadow[a[SH_AW-1:0]];  // Wraps like the RAM word index
    endfunction

    task automatic shadow_store(input lsu_pkg::store_size_e sz, input logic [31:0] a,
                                input logic [31:0] d);
        logic [SH_AW-1:0] base;
        case (sz)
            lsu_pkg::SZ_BYTE: begin
                shadow[a[SH_AW-1:0]] = d[7:0];
            end
            lsu_pkg::SZ_HALF: begin
                base                    = {a[SH_AW-1:1], 1'b0};
                shadow[base]            = d[7:0];
                shadow[base + SH_AW'(1)] = d[15:8];
            end
            default: begin
                base = {a[SH_AW-1:2], 2'b00};
                for (int k = 0; k < 4; k++) begin
                    shadow[base + SH_AW'(k)] = d[8*k +: 8];  // Little endian
                end
            end
        endcase
    endtask

    // Expected load result straight from the shadow bytes
    function automatic logic [31:0] ref_load(input lsu_pkg::mem_op_e op, input logic [31:0] a);
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] w;
        b = shadow_byte(a);
        h = {shadow_byte({a[31:1], 1'b1}), shadow_byte({a[31:1], 1'b0})};
        w = {shadow_byte({a[31:2], 2'd3}), shadow_byte({a[31:2], 2'd2}),
             shadow_byte({a[31:2], 2'd1}), shadow_byte({a[31:2], 2'd0})};
        case (op)
            lsu_pkg::OP_LB:  return {{24{b[7]}}, b};
            lsu_pkg::OP_LH:  return {{16{h[15]}}, h};
            lsu_pkg::OP_LBU: return {24'd0, b};
            lsu_pkg::OP_LHU: return {16'd0, h};
            default:         return w;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL %s got %h exp %h", name, got, exp);
            errors++;
        end
    endtask

    // Poll at falling edges, bounded
    task automatic wait_response(input logic dbg);
        int n;
        n = 0;
        while (!(dbg ? dbg_done_o : proc_ack_o) && n < TIMEOUT) begin
            @(negedge clk_i);
            n++;
        end
        if (!(dbg ? dbg_done_o : proc_ack_o)) begin
            $display("ERROR: no %s response within %0d cycles",
                     dbg ? "debug" : "processor", TIMEOUT);
            errors++;
        end
    endtask

    // ====================
    // Processor and debug accesses
    // ====================

    task automatic proc_start(input logic wr, input lsu_pkg::mem_op_e op,
                              input logic [31:0] a, input logic [31:0] d);
        proc_addr_i  = a;
        proc_wdata_i = d;
        proc_op_i    = op;
        proc_read_i  = !wr;
        proc_write_i = wr;
        exp_read     = !wr;
        exp_err      = (a >= wb_pkg::RAM_BYTES);   // Past the last RAM byte
        exp_rdata    = ref_load(op, a);
    endtask

    // Drop request the cycle after ack
    task automatic proc_finish;
        @(posedge clk_i);
        #2;
        if (proc_write_i && !exp_err) begin
            shadow_store(lsu_pkg::store_size_e'(proc_op_i[1:0]), proc_addr_i, proc_wdata_i);
        end
        proc_read_i  = 1'b0;
        proc_write_i = 1'b0;
        proc_pending = 1'b0;
    endtask

    task automatic proc_access(input logic wr, input lsu_pkg::mem_op_e op,
                               input logic [31:0] a, input logic [31:0] d);
        @(posedge clk_i);
        #2;
        proc_start(wr, op, a, d);
        proc_pending = 1'b1;
        @(negedge clk_i);
        check_value("proc_stall_o", 32'(proc_stall_o), 32'd1);  // Request cycle stalls
        wait_response(1'b0);
        proc_finish();
    endtask

    task automatic dbg_access(input logic wr, input lsu_pkg::store_size_e sz,
                              input logic [31:0] a, input logic [31:0] d);
        @(posedge clk_i);
        #2;
        dbg_en_i     = 1'b1;
        dbg_wr_i     = wr;
        dbg_addr_i   = a;
        dbg_wdata_i  = d;
        dbg_st_i     = wr ? {2'b00, sz} : {1'b0, lsu_pkg::OP_LB};  // Byte code, word comes back
        dbg_exp_read = !wr;
        dbg_exp_word = ref_load(lsu_pkg::OP_LW, a);  // Raw word, no alignment
        dbg_pending  = 1'b1;
        @(negedge clk_i);
        wait_response(1'b1);
        @(posedge clk_i);
        #2;
        if (wr) begin
            shadow_store(sz, a, d);
        end
        dbg_en_i    = 1'b0;
        dbg_wr_i    = 1'b0;
        dbg_pending = 1'b0;
    endtask

    // ====================
    // Compare process
    // ====================

    always @(negedge clk_i) begin
        if (proc_ack_o) begin
            if (!proc_pending) begin
                $display("ERROR: processor ack without an expected request");
                errors++;
            end else begin
                check_value("proc_err_o", 32'(proc_err_o), 32'(exp_err));
                if (exp_read && !exp_err) begin
                    check_value("proc_rdata_o", proc_rdata_o, exp_rdata);
                end
            end
        end
        if (dbg_done_o) begin
            if (!dbg_pending) begin
                $display("ERROR: debug done without a debug request");
                errors++;
            end else if (dbg_exp_read) begin
                check_value("dbg_rdata_o", dbg_rdata_o, dbg_exp_word);
            end
        end
    end

    // ====================
    // Stimulus
    // ====================

    initial begin
        logic [31:0] addr;
        logic [31:0] data;
        clk_i         = 1'b0;
        rst_n_i       = 1'b0;
        proc_addr_i   = '0;
        proc_wdata_i  = '0;
        proc_read_i   = 1'b0;
        proc_write_i  = 1'b0;
        proc_op_i     = lsu_pkg::OP_LW;
        core_halted_i = 1'b0;
        dbg_en_i      = 1'b0;
        dbg_wr_i      = 1'b0;
        dbg_st_i      = '0;
        dbg_addr_i    = '0;
        dbg_wdata_i   = '0;
        lfsr_q        = 16'd40756;
        errors        = 0;
        checks        = 0;
        proc_pending  = 1'b0;
        exp_read      = 1'b0;
        exp_err       = 1'b0;
        exp_rdata     = '0;
        dbg_pending   = 1'b0;
        dbg_exp_read  = 1'b0;
        dbg_exp_word  = '0;
        shadow        = '{default: 8'h00};  // RAM clears on reset

        repeat (16) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;

        // Quiet bus before any request
        repeat (4) begin
            @(negedge clk_i);
            check_value("proc_ack_o", 32'(proc_ack_o), 32'd0);
            check_value("dbg_done_o", 32'(dbg_done_o), 32'd0);
        end

        // Word store then load back
        repeat (16) begin
            addr = rand_bits(wb_pkg::RAM_AW) << 2;
            data = rand_bits(32);
            proc_access(1'b1, lsu_pkg::OP_LW, addr, data);
            proc_access(1'b0, lsu_pkg::OP_LW, addr, 32'd0);
        end

        // Sub-word stores, every load op at every legal offset
        repeat (8) begin
            addr = rand_bits(wb_pkg::RAM_AW) << 2;
            proc_access(1'b1, lsu_pkg::OP_LW, addr, rand_bits(32));
            proc_access(1'b1, lsu_pkg::OP_LB, addr | rand_bits(2), rand_bits(32));
            proc_access(1'b1, lsu_pkg::OP_LH, addr | (rand_bits(1) << 1), rand_bits(32));
            for (int off = 0; off < 4; off++) begin
                proc_access(1'b0, lsu_pkg::OP_LB, addr | off, 32'd0);
                proc_access(1'b0, lsu_pkg::OP_LBU, addr | off, 32'd0);
                if (off % 2 == 0) begin
                    proc_access(1'b0, lsu_pkg::OP_LH, addr | off, 32'd0);
                    proc_access(1'b0, lsu_pkg::OP_LHU, addr | off, 32'd0);
                end
            end
            proc_access(1'b0, lsu_pkg::OP_LW, addr, 32'd0);
        end

        // Out of range, error response and no aliased write
        addr = wb_pkg::RAM_BYTES + (rand_bits(wb_pkg::RAM_AW) << 2);
        proc_access(1'b1, lsu_pkg::OP_LW, addr, rand_bits(32));
        proc_access(1'b0, lsu_pkg::OP_LW, addr, 32'd0);
        proc_access(1'b0, lsu_pkg::OP_LW, addr - wb_pkg::RAM_BYTES, 32'd0);

        // Halted core, debug port owns the bus
        addr = rand_bits(wb_pkg::RAM_AW) << 2;
        @(posedge clk_i);
        #2;
        core_halted_i = 1'b1;
        proc_start(1'b0, lsu_pkg::OP_LH, addr | 32'd2, 32'd0);  // Held, must see no ack
        dbg_access(1'b1, lsu_pkg::SZ_WORD, addr, rand_bits(32));
        dbg_access(1'b1, lsu_pkg::SZ_BYTE, addr | rand_bits(2), rand_bits(32));
        dbg_access(1'b0, lsu_pkg::SZ_WORD, addr | 32'd3, 32'd0);
        dbg_access(1'b1, lsu_pkg::SZ_HALF, addr | 32'd2, rand_bits(32));
        dbg_access(1'b0, lsu_pkg::SZ_WORD, addr | 32'd1, 32'd0);
        @(negedge clk_i);
        check_value("proc_stall_o", 32'(proc_stall_o), 32'd1);

        // Held load completes once the halt ends
        @(posedge clk_i);
        #2;
        core_halted_i = 1'b0;
        exp_rdata     = ref_load(lsu_pkg::OP_LH, addr | 32'd2);
        proc_pending  = 1'b1;
        @(negedge clk_i);
        wait_response(1'b0);
        proc_finish();

        repeat (4) @(posedge clk_i);
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
